// ==== list.f ====
kbd_pkg.sv
kbd_frame_receiver.sv
kbd_gray_fifo.sv
kbd_controller.sv
tb_kbd_controller.sv

// ==== run.sh ====
#!/bin/sh
# build and run the kbd_controller testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_kbd_controller \
  -f list.f \
  -o tb_kbd_controller

status=0
./obj_dir/tb_kbd_controller > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  exit "$status"
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

// ==== tb_kbd_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_kbd_controller;
  import kbd_pkg::*;

  localparam int         BIT_NS       = 80;
  localparam int         MODEL_DEPTH  = 8;
  localparam int         READY_LIMIT  = 200;
  localparam logic [7:0] BREAK_PREFIX = 8'hF0;

  // what to break in the code frame of a row
  localparam logic [1:0] CORR_NONE   = 2'd0;
  localparam logic [1:0] CORR_PARITY = 2'd1;
  localparam logic [1:0] CORR_STOP   = 2'd2;

  // one stimulus row, code 00 means draw a random code
  typedef struct packed {
    logic [2:0] test;
    logic       scanf;
    logic       prefix;
    logic [7:0] code;
    logic [1:0] corrupt;
    logic       read_now;
  } row_t;

  logic       core_clk = 1'b0;
  logic       kbd_clk;
  logic       kbd_data;
  logic       rst_n;
  logic       scanf_en;
  logic       core_read_en;
  kbd_entry_t rd_entry;
  logic       data_ready;
  logic       valid_cc;

  row_t       rows[$];
  kbd_entry_t exp_q[$];
  logic       break_pending;
  integer     seed;
  int         n_checks;
  int         n_errors;

  kbd_controller dut0 (
    .kbd_clk      (kbd_clk),
    .kbd_data     (kbd_data),
    .core_clk     (core_clk),
    .rst_n        (rst_n),
    .scanf_en     (scanf_en),
    .core_read_en (core_read_en),
    .rd_entry     (rd_entry),
    .data_ready   (data_ready),
    .valid_cc     (valid_cc)
  );

  // 8 ns core clock
  always #4 core_clk = ~core_clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("FAILED %s expected %0h actual %0h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic add_row(input logic [2:0] test, input logic scanf, input logic prefix,
                         input logic [7:0] code, input logic [1:0] corrupt,
                         input logic read_now);
    rows.push_back('{test, scanf, prefix, code, corrupt, read_now});
  endtask

  task automatic load_table();
    // 1: a single release with a random code
    add_row(3'd1, 1'b1, 1'b1, 8'h00, CORR_NONE, 1'b1);
    // 2: make codes alone store nothing
    add_row(3'd2, 1'b1, 1'b0, 8'h1c, CORR_NONE, 1'b0);
    add_row(3'd2, 1'b1, 1'b0, 8'h32, CORR_NONE, 1'b0);
    add_row(3'd2, 1'b1, 1'b0, 8'h00, CORR_NONE, 1'b1);
    // 3: bad parity after a prefix, then a plain code
    // the plain code only shows up if the prefix was not cancelled
    add_row(3'd3, 1'b1, 1'b1, 8'h00, CORR_PARITY, 1'b1);
    add_row(3'd3, 1'b1, 1'b0, 8'h2b, CORR_NONE, 1'b1);
    // 4: stop bit low, alone and after a prefix
    add_row(3'd4, 1'b1, 1'b0, 8'h4d, CORR_STOP, 1'b1);
    add_row(3'd4, 1'b1, 1'b1, 8'h00, CORR_STOP, 1'b1);
    // 5: releases while disabled, then enabled again
    add_row(3'd5, 1'b0, 1'b1, 8'h00, CORR_NONE, 1'b0);
    add_row(3'd5, 1'b0, 1'b1, 8'h00, CORR_NONE, 1'b1);
    add_row(3'd5, 1'b1, 1'b1, 8'h00, CORR_NONE, 1'b1);
    // 6: ten releases into eight slots, then drain plus one read on empty
    for (int i = 0; i < 10; i++) begin
      add_row(3'd6, 1'b1, 1'b1, 8'h00, CORR_NONE, 1'b0);
    end
    for (int i = 0; i < 9; i++) begin
      add_row(3'd6, 1'b1, 1'b0, 8'h1c, CORR_NONE, 1'b1);
    end
  endtask

  // 00..7f never collides with the break prefix
  function automatic logic [7:0] random_code();
    logic [7:0] c;
    c = 8'($random(seed)) & 8'h7f;
    if (c == 8'h00) begin
      c = 8'h01;
    end
    return c;
  endfunction

  // one kbd_clk period, 5 core cycles low then 5 high
  // data moves early in the low phase
  task automatic clock_bit(input logic value);
    @(posedge core_clk);
    kbd_data <= value;
    repeat (4) @(posedge core_clk);
    kbd_clk <= 1'b1;
    repeat (5) @(posedge core_clk);
    kbd_clk <= 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] code, input logic [1:0] corrupt);
    kbd_frame_t frame;
    frame.start      = 1'b0;
    frame.data       = code;
    frame.odd_parity = ~(^code);
    frame.stop       = 1'b1;
    if (corrupt == CORR_PARITY) begin
      frame.odd_parity = ~frame.odd_parity;
    end
    if (corrupt == CORR_STOP) begin
      frame.stop = 1'b0;
    end
    // lsb first, start bit leads
    for (int i = 0; i < 11; i++) begin
      clock_bit(frame[i]);
    end
    // idle clocks so the registered write reaches the fifo
    clock_bit(1'b1);
    clock_bit(1'b1);
  endtask

  task automatic push_expected(input kbd_entry_t e);
    // a full fifo drops the new entry
    if (exp_q.size() < MODEL_DEPTH) begin
      exp_q.push_back(e);
    end
  endtask

  // frame level release rules
  task automatic model_frame(input logic [7:0] code, input logic [1:0] corrupt,
                             input logic scanf);
    kbd_entry_t e;
    e.err  = (corrupt != CORR_NONE);
    e.code = code;
    if (!scanf) begin
      break_pending = 1'b0;
    end else if (e.err) begin
      push_expected(e);
      break_pending = 1'b0;
    end else if (code == BREAK_PREFIX) begin
      break_pending = 1'b1;
    end else begin
      if (break_pending) begin
        push_expected(e);
      end
      break_pending = 1'b0;
    end
  endtask

  task automatic read_and_check(input int row);
    kbd_entry_t exp_e;
    int         waited;
    if (exp_q.size() == 0) begin
      // nothing expected, the read must not pop anything
      repeat (4) @(posedge core_clk);
      check_value("data_ready", 32'(1'b0), 32'(data_ready));
      core_read_en <= 1'b1;
      @(posedge core_clk);
      check_value("valid_cc", 32'(1'b0), 32'(valid_cc));
      core_read_en <= 1'b0;
    end else begin
      exp_e  = exp_q.pop_front();
      waited = 0;
      do begin
        @(posedge core_clk);
        waited++;
      end while (!data_ready && waited < READY_LIMIT);
      if (!data_ready) begin
        n_errors++;
        $display("data_ready stayed low for %0d core cycles with an entry due, row %0d",
                 waited, row);
      end else begin
        // head is visible before the pop
        check_value("rd_entry", 32'(exp_e), 32'(rd_entry));
        core_read_en <= 1'b1;
        @(posedge core_clk);
        check_value("valid_cc", 32'(1'b1), 32'(valid_cc));
        core_read_en <= 1'b0;
      end
    end
  endtask

  initial begin
    row_t       r;
    logic [7:0] code;
    int         test_checks;
    int         test_errors;
    kbd_clk       <= 1'b0;
    kbd_data      <= 1'b1;
    rst_n         <= 1'b0;
    scanf_en      <= 1'b0;
    core_read_en  <= 1'b0;
    seed          = 32'hcfe8_8ba1;
    break_pending = 1'b0;
    n_checks      = 0;
    n_errors      = 0;
    load_table();

    // fast idle pulses, two rising edges fall inside reset
    for (int i = 0; i < 8; i++) begin
      @(posedge core_clk);
      kbd_clk <= ~kbd_clk;
      if (i == 3) begin
        rst_n <= 1'b1;
      end
    end
    test_checks = 0;
    test_errors = 0;
    repeat (4) @(posedge core_clk);
    check_value("data_ready", 32'(1'b0), 32'(data_ready));
    check_value("valid_cc", 32'(1'b0), 32'(valid_cc));

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      @(posedge core_clk);
      scanf_en <= r.scanf;
      code = (r.code == 8'h00) ? random_code() : r.code;
      if (r.prefix) begin
        send_frame(BREAK_PREFIX, CORR_NONE);
        model_frame(BREAK_PREFIX, CORR_NONE, r.scanf);
      end
      send_frame(code, r.corrupt);
      model_frame(code, r.corrupt, r.scanf);
      if (r.read_now) begin
        read_and_check(i);
      end
      // last row of a test
      if (i == rows.size() - 1 || rows[i + 1].test != r.test) begin
        $display("test %0d %s, %0d checks, %0d errors", r.test,
                 (n_errors == test_errors) ? "passed" : "failed",
                 n_checks - test_checks, n_errors - test_errors);
        test_checks = n_checks;
        test_errors = n_errors;
      end
    end

    $display("all tests done, %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // rows times two frames of eleven bits, twice over
  initial begin
    longint limit_ns;
    #1;
    limit_ns = longint'(rows.size()) * 2 * 11 * BIT_NS * 2;
    #(limit_ns);
    $display("timeout, the run was still going after %0d ns", limit_ns);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== kbd_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_controller #(
  parameter logic [7:0] BREAK_CODE = kbd_pkg::KBD_BREAK_CODE_DEF,
  parameter int         FIFO_AW    = kbd_pkg::KBD_FIFO_AW_DEF
) (
  // keyboard lines
  input  logic                kbd_clk,
  input  logic                kbd_data,
  // core side
  input  logic                core_clk,
  input  logic                rst_n,
  input  logic                scanf_en,
  input  logic                core_read_en,
  output kbd_pkg::kbd_entry_t rd_entry,
  output logic                data_ready,
  output logic                valid_cc
);
  import kbd_pkg::*;

  // receiver to fifo, all in kbd_clk
  logic       wr_en;
  kbd_entry_t wr_entry;
  logic       full;

  // frame capture, checks and release detection
  kbd_frame_receiver #(
    .BREAK_CODE (BREAK_CODE)
  ) rx0 (
    .kbd_clk  (kbd_clk),
    .kbd_data (kbd_data),
    .rst_n    (rst_n),
    .scanf_en (scanf_en),
    .full     (full),
    .wr_en    (wr_en),
    .wr_entry (wr_entry)
  );

  // crossing into core_clk
  kbd_gray_fifo #(
    .FIFO_AW (FIFO_AW)
  ) fifo0 (
    .kbd_clk    (kbd_clk),
    .core_clk   (core_clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_entry   (wr_entry),
    .full       (full),
    .rd_en      (core_read_en),
    .rd_entry   (rd_entry),
    .data_ready (data_ready)
  );

  // high in the same cycle the head is popped
  assign valid_cc = data_ready & core_read_en;

endmodule

`default_nettype wire

// ==== kbd_gray_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_gray_fifo #(
  parameter int FIFO_AW = kbd_pkg::KBD_FIFO_AW_DEF
) (
  input  logic                kbd_clk,
  input  logic                core_clk,
  input  logic                rst_n,
  input  logic                wr_en,
  input  kbd_pkg::kbd_entry_t wr_entry,
  output logic                full,
  input  logic                rd_en,
  output kbd_pkg::kbd_entry_t rd_entry,
  output logic                data_ready
);
  import kbd_pkg::*;

  localparam int DEPTH = 1 << FIFO_AW;

  // gray pointers of a full fifo differ only in their top two bits
  localparam logic [FIFO_AW:0] GRAY_FULL_MASK = (FIFO_AW + 1)'(3) << (FIFO_AW - 1);

  kbd_entry_t       mem [DEPTH];

  // write side, kbd_clk
  logic [1:0]       wr_rst_sync;
  logic             wr_rst_n;
  logic [FIFO_AW:0] wr_bin;
  logic [FIFO_AW:0] wr_bin_next;
  logic [FIFO_AW:0] wr_gray;
  logic [FIFO_AW:0] wr_gray_next;
  logic [FIFO_AW:0] rd_gray_kc1;
  logic [FIFO_AW:0] rd_gray_kc2;
  logic             push;

  // read side, core_clk
  logic [FIFO_AW:0] rd_bin;
  logic [FIFO_AW:0] rd_bin_next;
  logic [FIFO_AW:0] rd_gray;
  logic [FIFO_AW:0] rd_gray_next;
  logic [FIFO_AW:0] wr_gray_cc1;
  logic [FIFO_AW:0] wr_gray_cc2;
  logic             pop;

  // write side gets its own copy of the core reset
  always_ff @(posedge kbd_clk) begin
    wr_rst_sync <= {wr_rst_sync[0], rst_n};
  end

  assign wr_rst_n = wr_rst_sync[1];

  // writes into a full fifo are ignored here as well
  assign push = wr_en && !full;

  assign wr_bin_next  = wr_bin + (FIFO_AW + 1)'(push);
  assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

  always_ff @(posedge kbd_clk) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_gray_next;
    end
  end

  // storage, low address bits only
  always_ff @(posedge kbd_clk) begin
    if (push) begin
      mem[wr_bin[FIFO_AW-1:0]] <= wr_entry;
    end
  end

  // read pointer into the kbd_clk domain
  always_ff @(posedge kbd_clk) begin
    if (!wr_rst_n) begin
      rd_gray_kc1 <= '0;
      rd_gray_kc2 <= '0;
    end else begin
      rd_gray_kc1 <= rd_gray;
      rd_gray_kc2 <= rd_gray_kc1;
    end
  end

  // full lags a read by the synchronizer, so it can only be pessimistic
  assign full = ((wr_gray ^ rd_gray_kc2) == GRAY_FULL_MASK);

  // write pointer into the core_clk domain
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      wr_gray_cc1 <= '0;
      wr_gray_cc2 <= '0;
    end else begin
      wr_gray_cc1 <= wr_gray;
      wr_gray_cc2 <= wr_gray_cc1;
    end
  end

  // pop only when something is there
  assign pop = rd_en && data_ready;

  assign rd_bin_next  = rd_bin + (FIFO_AW + 1)'(pop);
  assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_gray_next;
    end
  end

  // registered not-empty, compared against the pointer after this pop
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      data_ready <= 1'b0;
    end else begin
      data_ready <= (rd_gray_next != wr_gray_cc2);
    end
  end

  // first word fall through, head is always visible
  assign rd_entry = mem[rd_bin[FIFO_AW-1:0]];

endmodule

`default_nettype wire

// ==== kbd_frame_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_frame_receiver #(
  parameter logic [7:0] BREAK_CODE = kbd_pkg::KBD_BREAK_CODE_DEF
) (
  input  logic                kbd_clk,
  input  logic                kbd_data,
  input  logic                rst_n,
  input  logic                scanf_en,
  input  logic                full,
  output logic                wr_en,
  output kbd_pkg::kbd_entry_t wr_entry
);
  import kbd_pkg::*;

  // reset and enable arrive from the core domain
  logic [1:0]    rst_sync;
  logic          rst_kc_n;
  logic [1:0]    scanf_sync;
  logic          scanf_kc;

  // frame capture
  kbd_rx_state_t state;
  logic [3:0]    bit_cnt;
  kbd_frame_t    frame_q;
  kbd_frame_t    frame_next;
  logic          frame_done;

  // frame evaluation
  logic          framing_err;
  logic          parity_err;
  logic          frame_err;
  logic          is_break;
  logic          break_flag;
  logic          push_req;

  // two flops carry the core reset onto kbd_clk
  // the keyboard clock must toggle while rst_n is low for this to take
  always_ff @(posedge kbd_clk) begin
    rst_sync <= {rst_sync[0], rst_n};
  end

  assign rst_kc_n = rst_sync[1];

  // software enable, two kbd_clk edges late
  always_ff @(posedge kbd_clk) begin
    if (!rst_kc_n) begin
      scanf_sync <= 2'b00;
    end else begin
      scanf_sync <= {scanf_sync[0], scanf_en};
    end
  end

  assign scanf_kc = scanf_sync[1];

  // next shift register value with the bit on the line now
  // on the 11th edge this is the complete frame
  assign frame_next = {kbd_data, frame_q[10:1]};

  // free running shift, only the last eleven bits of a frame matter
  always_ff @(posedge kbd_clk) begin
    frame_q <= frame_next;
  end

  // bit_cnt counts bits already taken, the start bit is bit 1
  always_ff @(posedge kbd_clk) begin
    if (!rst_kc_n) begin
      state   <= rx_idle;
      bit_cnt <= 4'd0;
    end else begin
      case (state)
        rx_idle: begin
          // low data on a clock edge is a start bit
          if (!kbd_data) begin
            state   <= rx_shift;
            bit_cnt <= 4'd1;
          end
        end
        rx_shift: begin
          if (bit_cnt == 4'd10) begin
            state   <= rx_idle;
            bit_cnt <= 4'd0;
          end else begin
            bit_cnt <= bit_cnt + 4'd1;
          end
        end
        default: begin
          state   <= rx_idle;
          bit_cnt <= 4'd0;
        end
      endcase
    end
  end

  // stop bit is being sampled on this edge
  assign frame_done = (state == rx_shift) && (bit_cnt == 4'd10);

  // start must be 0 and stop must be 1
  assign framing_err = (frame_next.start != 1'b0) || (frame_next.stop != 1'b1);

  // odd parity over data and parity bit
  assign parity_err = ~(^{frame_next.data, frame_next.odd_parity});

  assign frame_err = framing_err | parity_err;
  assign is_break  = (frame_next.data == BREAK_CODE);

  // errors always go out, good codes only right after a break prefix
  assign push_req = frame_done && scanf_kc && (frame_err || (break_flag && !is_break));

  // break flag holds across exactly one following frame
  always_ff @(posedge kbd_clk) begin
    if (!rst_kc_n) begin
      break_flag <= 1'b0;
    end else if (!scanf_kc) begin
      break_flag <= 1'b0;
    end else if (frame_done) begin
      // any frame other than a clean prefix ends the sequence
      break_flag <= !frame_err && is_break;
    end
  end

  // write strobe lasts one kbd_clk cycle
  // a frame finishing into a full fifo is lost
  always_ff @(posedge kbd_clk) begin
    if (!rst_kc_n) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= push_req && !full;
    end
  end

  // entry payload, raw data bits even on error
  always_ff @(posedge kbd_clk) begin
    if (frame_done) begin
      wr_entry.err  <= frame_err;
      wr_entry.code <= frame_next.data;
    end
  end

endmodule

`default_nettype wire

// ==== kbd_pkg.sv ====
`default_nettype none

package kbd_pkg;

  // one ps/2 frame as it sits in the receive shift register
  // bits arrive lsb first, so the start bit ends up at bit 0
  typedef struct packed {
    logic       stop;
    logic       odd_parity;
    logic [7:0] data;
    logic       start;
  } kbd_frame_t;

  // one fifo entry handed to the core
  // err marks a frame that failed start, stop or parity checks
  typedef struct packed {
    logic       err;
    logic [7:0] code;
  } kbd_entry_t;

  // receiver fsm
  // rx_idle waits for a start bit, rx_shift collects the other ten bits
  typedef enum logic {
    rx_idle,
    rx_shift
  } kbd_rx_state_t;

  // break prefix of scan code set 2
  localparam logic [7:0] KBD_BREAK_CODE_DEF = 8'hF0;

  // fifo depth exponent, 8 entries
  localparam int KBD_FIFO_AW_DEF = 3;

endpackage

`default_nettype wire
